/* rtl/uart_ctrl_pkg.sv */
// --------------------
// UART main controller package
// Packet layout, configuration and error types, and the constants of the
// configuration handshake shared by the negotiator and its helpers
// --------------------

`default_nettype none

package uart_ctrl_pkg;

  // One serial data packet as it leaves or enters the shift registers
  typedef logic [7:0] packet_t;

  // Identifier carried in a configuration packet
  typedef enum logic [1:0] {
    ID_DATA_WIDTH  = 2'b00,
    ID_PARITY_MODE = 2'b01,
    ID_STOP_BITS   = 2'b10,
    ID_END         = 2'b11
  } cfg_id_e;

  typedef enum logic [1:0] {
    DW_5BIT = 2'b00,
    DW_6BIT = 2'b01,
    DW_7BIT = 2'b10,
    DW_8BIT = 2'b11
  } data_width_e;

  // Both upper codes switch parity off
  typedef enum logic [1:0] {
    PAR_EVEN  = 2'b00,
    PAR_ODD   = 2'b01,
    PAR_NONE  = 2'b10,
    PAR_NONE2 = 2'b11
  } parity_mode_e;

  typedef enum logic [1:0] {
    SB_1   = 2'b00,
    SB_15  = 2'b01,
    SB_2   = 2'b10,
    SB_RSV = 2'b11
  } stop_bits_e;

  // Active line configuration
  typedef struct packed {
    data_width_e  data_width;
    parity_mode_e parity_mode;
    stop_bits_e   stop_bits;
  } uart_cfg_s;

  // Configuration packet, marker nibble on top and the option in the low bits
  typedef struct packed {
    logic [3:0] marker;
    cfg_id_e    id;
    logic [1:0] option;
  } cfg_pkt_s;

  // Sticky error flags seen by the CPU
  typedef struct packed {
    logic configuration;
    logic parity;
    logic frame;
    logic overrun;
  } uart_error_s;

  // Counter used while waiting for the peer
  typedef logic [5:0] timeout_cnt_t;

  localparam logic [3:0] CFG_MARKER = 4'hA;

  // The upper nibble differs from the marker so an acknowledgment never looks like a cfg packet
  localparam packet_t ACK_PKT = 8'hF0;

  localparam uart_cfg_s STD_CFG = '{data_width: DW_8BIT, parity_mode: PAR_EVEN, stop_bits: SB_1};

  localparam int unsigned ACK_TIMEOUT_CYCLES = 40;

  // Extra line requests sent before the master gives up
  localparam int unsigned MAX_RETRIES = 3;

  // Negotiator state machine
  typedef enum logic [3:0] {
    RESET            = 4'd0,
    IDLE             = 4'd1,
    STD_LOAD         = 4'd2,
    MST_REQ          = 4'd3,
    MST_WAIT_REQ_ACK = 4'd4,
    MST_SEND         = 4'd5,
    MST_WAIT_TX      = 4'd6,
    MST_WAIT_ACK     = 4'd7,
    SLV_SEND_ACK     = 4'd8,
    SLV_WAIT_TX      = 4'd9,
    SLV_WAIT_PKT     = 4'd10
  } neg_state_e;

endpackage

`default_nettype wire

/* rtl/cfg_negotiator.sv */
// --------------------
// Configuration negotiator
// Runs the master and slave sides of the configuration handshake with the
// peer and owns the active configuration register
// --------------------

`default_nettype none

module cfg_negotiator (
  input  wire logic                     clk_i,
  input  wire logic                     rst_n_i,
  input  wire uart_ctrl_pkg::uart_cfg_s cfg_i,
  input  wire logic                     std_cfg_i,
  input  wire logic                     cfg_req_mst_i,
  input  wire logic                     cfg_req_slv_i,
  input  wire logic                     req_done_i,
  input  wire logic                     rx_valid_i,
  input  wire uart_ctrl_pkg::packet_t   rx_data_i,
  input  wire logic                     tx_done_i,
  output logic                          line_req_o,
  output logic                          tx_valid_o,
  output uart_ctrl_pkg::packet_t        tx_data_o,
  output uart_ctrl_pkg::uart_cfg_s      cfg_o,
  output logic                          cfg_done_o,
  output logic                          cfg_fail_o
);

  import uart_ctrl_pkg::*;

  // Last count of a wait before it is treated as a timeout
  localparam timeout_cnt_t TIMER_LAST = timeout_cnt_t'(ACK_TIMEOUT_CYCLES - 1);
  localparam int unsigned RETRY_W = $clog2(MAX_RETRIES + 1);

  neg_state_e           state_q, state_d;
  cfg_id_e              pkt_idx_q, pkt_idx_d;
  logic [RETRY_W-1:0]   retry_q, retry_d;
  timeout_cnt_t         timer_q, timer_d;
  uart_cfg_s            cfg_q, cfg_d;
  uart_cfg_s            mst_cfg_q;
  logic                 fail_q, fail_d;
  logic                 load_mst;
  logic                 ack_seen;
  logic                 timed_out;
  logic                 slv_tx;
  cfg_pkt_s             rx_pkt;

  // Builds the outgoing configuration packet for one field
  function automatic packet_t build_pkt(cfg_id_e id, uart_cfg_s cfg);
    cfg_pkt_s pkt;
    pkt.marker = CFG_MARKER;
    pkt.id     = id;
    case (id)
      ID_DATA_WIDTH:  pkt.option = cfg.data_width;
      ID_PARITY_MODE: pkt.option = cfg.parity_mode;
      ID_STOP_BITS:   pkt.option = cfg.stop_bits;
      default:        pkt.option = 2'b00;
    endcase
    return packet_t'(pkt);
  endfunction

  assign rx_pkt    = cfg_pkt_s'(rx_data_i);
  assign ack_seen  = rx_valid_i && (rx_data_i == ACK_PKT);
  assign timed_out = (timer_q == TIMER_LAST);

  // --------------------
  // Next state logic
  // --------------------

  always_comb begin
    state_d   = state_q;
    pkt_idx_d = pkt_idx_q;
    retry_d   = retry_q;
    cfg_d     = cfg_q;
    fail_d    = 1'b0;
    load_mst  = 1'b0;
    // The timer only runs in the three wait states and restarts everywhere else
    timer_d   = '0;

    case (state_q)
      RESET: begin
        state_d = IDLE;
      end

      IDLE: begin
        pkt_idx_d = ID_DATA_WIDTH;
        retry_d   = '0;
        // A request from the peer wins over our own request
        if (cfg_req_slv_i) begin
          state_d = SLV_SEND_ACK;
        end else if (cfg_req_mst_i) begin
          load_mst = 1'b1;
          state_d  = MST_REQ;
        end else if (std_cfg_i) begin
          state_d = STD_LOAD;
        end
      end

      STD_LOAD: begin
        cfg_d   = STD_CFG;
        state_d = IDLE;
      end

      // Line request held until the transmitter reports it finished
      MST_REQ: begin
        if (req_done_i) begin
          state_d = MST_WAIT_REQ_ACK;
        end
      end

      MST_WAIT_REQ_ACK: begin
        timer_d = timer_q + 1'b1;
        if (ack_seen) begin
          state_d = MST_SEND;
        end else if (timed_out) begin
          if (retry_q == RETRY_W'(MAX_RETRIES)) begin
            fail_d  = 1'b1;
            state_d = STD_LOAD;
          end else begin
            retry_d = retry_q + 1'b1;
            state_d = MST_REQ;
          end
        end
      end

      // Done may already arrive in the first cycle of a transmission
      MST_SEND, MST_WAIT_TX: begin
        state_d = tx_done_i ? MST_WAIT_ACK : MST_WAIT_TX;
      end

      MST_WAIT_ACK: begin
        timer_d = timer_q + 1'b1;
        if (ack_seen) begin
          if (pkt_idx_q == ID_END) begin
            // Peer accepted the whole set, so it becomes the active configuration
            cfg_d   = mst_cfg_q;
            state_d = IDLE;
          end else begin
            pkt_idx_d = cfg_id_e'(pkt_idx_q + 1'b1);
            state_d   = MST_SEND;
          end
        end else if (timed_out) begin
          fail_d  = 1'b1;
          state_d = STD_LOAD;
        end
      end

      SLV_SEND_ACK, SLV_WAIT_TX: begin
        if (tx_done_i) begin
          // pkt_idx holds the id of the packet just acknowledged
          state_d = (pkt_idx_q == ID_END) ? IDLE : SLV_WAIT_PKT;
        end else begin
          state_d = SLV_WAIT_TX;
        end
      end

      SLV_WAIT_PKT: begin
        timer_d = timer_q + 1'b1;
        if (rx_valid_i && (rx_pkt.marker == CFG_MARKER)) begin
          case (rx_pkt.id)
            ID_DATA_WIDTH:  cfg_d.data_width  = data_width_e'(rx_pkt.option);
            ID_PARITY_MODE: cfg_d.parity_mode = parity_mode_e'(rx_pkt.option);
            ID_STOP_BITS:   cfg_d.stop_bits   = stop_bits_e'(rx_pkt.option);
            default:        cfg_d = cfg_q;
          endcase
          pkt_idx_d = rx_pkt.id;
          state_d   = SLV_SEND_ACK;
        end else if (timed_out) begin
          fail_d  = 1'b1;
          state_d = STD_LOAD;
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // --------------------
  // Registers
  // --------------------

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q   <= RESET;
      pkt_idx_q <= ID_DATA_WIDTH;
      retry_q   <= '0;
      timer_q   <= '0;
      cfg_q     <= STD_CFG;
      fail_q    <= 1'b0;
    end else begin
      state_q   <= state_d;
      pkt_idx_q <= pkt_idx_d;
      retry_q   <= retry_d;
      timer_q   <= timer_d;
      cfg_q     <= cfg_d;
      fail_q    <= fail_d;
    end
  end

  // Snapshot of the requested configuration, kept stable for the whole exchange
  always_ff @(posedge clk_i) begin
    if (load_mst) begin
      mst_cfg_q <= cfg_i;
    end
  end

  // --------------------
  // Outputs
  // --------------------

  assign slv_tx     = (state_q == SLV_SEND_ACK) || (state_q == SLV_WAIT_TX);
  assign line_req_o = (state_q == MST_REQ);
  assign tx_valid_o = slv_tx || (state_q == MST_SEND) || (state_q == MST_WAIT_TX);

  // The slave only ever sends acknowledgments
  assign tx_data_o  = slv_tx ? ACK_PKT : build_pkt(pkt_idx_q, mst_cfg_q);
  assign cfg_o      = cfg_q;
  assign cfg_done_o = (state_q == IDLE);
  assign cfg_fail_o = fail_q;

endmodule

`default_nettype wire

/* rtl/parity_checker.sv */
// --------------------
// Parity checker
// Compares the received parity bit with the parity of the data bits under
// the active width and mode
// --------------------

`default_nettype none

module parity_checker (
  input  wire uart_ctrl_pkg::uart_cfg_s cfg_i,
  input  wire logic                     rx_valid_i,
  input  wire uart_ctrl_pkg::packet_t   rx_data_i,
  input  wire logic                     rx_parity_i,
  input  wire logic                     enable_i,
  output logic                          par_err_o
);

  import uart_ctrl_pkg::*;

  logic data_xor;
  logic mismatch;

  always_comb begin
    // Only the bits inside the active width take part
    case (cfg_i.data_width)
      DW_5BIT: data_xor = ^rx_data_i[4:0];
      DW_6BIT: data_xor = ^rx_data_i[5:0];
      DW_7BIT: data_xor = ^rx_data_i[6:0];
      default: data_xor = ^rx_data_i;
    endcase

    // Odd parity expects the inverted XOR, the two no-parity codes never fail
    case (cfg_i.parity_mode)
      PAR_EVEN: mismatch = (rx_parity_i != data_xor);
      PAR_ODD:  mismatch = (rx_parity_i != ~data_xor);
      default:  mismatch = 1'b0;
    endcase
  end

  // No check while the configuration is being negotiated
  assign par_err_o = enable_i && rx_valid_i && mismatch;

endmodule

`default_nettype wire

/* rtl/error_collector.sv */
// --------------------
// Error collector
// Turns single-cycle error events into sticky flags that stay set until
// the CPU acknowledges the interrupt
// --------------------

`default_nettype none

module error_collector (
  input  wire logic            clk_i,
  input  wire logic            rst_n_i,
  input  wire logic            cfg_fail_i,
  input  wire logic            par_err_i,
  input  wire logic            rx_valid_i,
  input  wire logic            frame_error_i,
  input  wire logic            overrun_error_i,
  input  wire logic            irq_ack_i,
  output uart_ctrl_pkg::uart_error_s error_o
);

  import uart_ctrl_pkg::*;

  uart_error_s err_q;
  uart_error_s err_d;
  uart_error_s err_set;

  // Events of this cycle, frame and overrun only count with a received packet
  always_comb begin
    err_set.configuration = cfg_fail_i;
    err_set.parity        = par_err_i;
    err_set.frame         = rx_valid_i && frame_error_i;
    err_set.overrun       = rx_valid_i && overrun_error_i;
  end

  // Acknowledge clears the old flags, a new event in the same cycle still lands
  assign err_d = err_set | (irq_ack_i ? uart_error_s'('0) : err_q);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      err_q <= '0;
    end else begin
      err_q <= err_d;
    end
  end

  assign error_o = err_q;

endmodule

`default_nettype wire

/* rtl/uart_main_ctrl.sv */
// --------------------
// UART main controller
// Negotiator and parity checker side by side, both feeding the error
// collector
// --------------------

`default_nettype none

module uart_main_ctrl (
  input  wire logic                     clk_i,
  input  wire logic                     rst_n_i,
  // CPU side
  input  wire uart_ctrl_pkg::uart_cfg_s cfg_i,
  input  wire logic                     std_cfg_i,
  input  wire logic                     cfg_req_mst_i,
  input  wire logic                     cfg_req_slv_i,
  input  wire logic                     irq_ack_i,
  // Receiver
  input  wire logic                     rx_valid_i,
  input  wire uart_ctrl_pkg::packet_t   rx_data_i,
  input  wire logic                     rx_parity_i,
  input  wire logic                     frame_error_i,
  input  wire logic                     overrun_error_i,
  // Transmitter
  input  wire logic                     req_done_i,
  input  wire logic                     tx_done_i,
  output logic                          line_req_o,
  output logic                          tx_valid_o,
  output uart_ctrl_pkg::packet_t        tx_data_o,
  // Status
  output uart_ctrl_pkg::uart_cfg_s      cfg_o,
  output logic                          cfg_done_o,
  output uart_ctrl_pkg::uart_error_s    error_o
);

  logic par_err;
  logic cfg_fail;

  cfg_negotiator u_negotiator (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .cfg_i         (cfg_i),
    .std_cfg_i     (std_cfg_i),
    .cfg_req_mst_i (cfg_req_mst_i),
    .cfg_req_slv_i (cfg_req_slv_i),
    .req_done_i    (req_done_i),
    .rx_valid_i    (rx_valid_i),
    .rx_data_i     (rx_data_i),
    .tx_done_i     (tx_done_i),
    .line_req_o    (line_req_o),
    .tx_valid_o    (tx_valid_o),
    .tx_data_o     (tx_data_o),
    .cfg_o         (cfg_o),
    .cfg_done_o    (cfg_done_o),
    .cfg_fail_o    (cfg_fail)
  );

  // Checks run against the active configuration, and only outside a negotiation
  parity_checker u_parity (
    .cfg_i       (cfg_o),
    .rx_valid_i  (rx_valid_i),
    .rx_data_i   (rx_data_i),
    .rx_parity_i (rx_parity_i),
    .enable_i    (cfg_done_o),
    .par_err_o   (par_err)
  );

  error_collector u_errors (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .cfg_fail_i      (cfg_fail),
    .par_err_i       (par_err),
    .rx_valid_i      (rx_valid_i),
    .frame_error_i   (frame_error_i),
    .overrun_error_i (overrun_error_i),
    .irq_ack_i       (irq_ack_i),
    .error_o         (error_o)
  );

endmodule

`default_nettype wire

/* dv/ctrl_model.svh */
// --------------------
// Peer device model
// Answers line requests and transmissions of the controller and predicts
// configuration packets and parity errors
// --------------------

`ifndef CTRL_MODEL_SVH
`define CTRL_MODEL_SVH

// A peer that is busy for 0 to 5 cycles before it reacts
task automatic peer_delay();
  int unsigned n;
  n = $urandom_range(5, 0);
  repeat (n) @(negedge clk_i);
endtask

// Ends a pending line request with a one-cycle done pulse
task automatic answer_line_req();
  peer_delay();
  req_done_i = 1'b1;
  @(negedge clk_i);
  req_done_i = 1'b0;
endtask

// Sends one packet to the controller as a single-cycle valid pulse
task automatic send_rx_pkt(input packet_t pkt);
  peer_delay();
  rx_valid_i = 1'b1;
  rx_data_i  = pkt;
  @(negedge clk_i);
  rx_valid_i = 1'b0;
endtask

// Waits for a transmit, takes its packet and ends it with tx done
task automatic accept_tx(output packet_t pkt);
  while (!tx_valid_o) begin
    @(negedge clk_i);
  end
  pkt = tx_data_o;
  peer_delay();
  tx_done_i = 1'b1;
  @(negedge clk_i);
  tx_done_i = 1'b0;
endtask

// Packet number idx of a negotiation with the marker on top and the field as option
function automatic packet_t expected_cfg_pkt(input int unsigned idx, input uart_cfg_s cfg);
  cfg_id_e    id;
  logic [1:0] opt;
  case (idx)
    0: begin
      id  = ID_DATA_WIDTH;
      opt = cfg.data_width;
    end
    1: begin
      id  = ID_PARITY_MODE;
      opt = cfg.parity_mode;
    end
    2: begin
      id  = ID_STOP_BITS;
      opt = cfg.stop_bits;
    end
    // The end packet carries no field
    default: begin
      id  = ID_END;
      opt = 2'b00;
    end
  endcase
  return {CFG_MARKER, id, opt};
endfunction

// Parity rule over the low 5 to 8 data bits
function automatic logic expected_par_err(input uart_cfg_s cfg, input packet_t data,
                                          input logic par);
  int unsigned nbits;
  int unsigned i;
  logic        x;
  nbits = 5 + int'(cfg.data_width);
  x = 1'b0;
  for (i = 0; i < nbits; i++) begin
    x = x ^ data[i];
  end
  if (cfg.parity_mode == PAR_EVEN) return par != x;
  if (cfg.parity_mode == PAR_ODD) return par == x;
  return 1'b0;
endfunction

`endif

/* dv/tb_uart_main_ctrl.sv */
// --------------------
// Testbench for the UART main controller
// Random peer behavior from a fixed seed, checked against the peer model
// --------------------

`default_nettype none

module tb_uart_main_ctrl;

  import uart_ctrl_pkg::*;

  // Longest run allows every test to stall for several full timeouts
  localparam int unsigned CYCLE_LIMIT = 6 * (ACK_TIMEOUT_CYCLES * (MAX_RETRIES + 2) + 200);

  logic        clk_i;
  logic        rst_n_i;
  uart_cfg_s   cfg_i;
  logic        std_cfg_i;
  logic        cfg_req_mst_i;
  logic        cfg_req_slv_i;
  logic        irq_ack_i;
  logic        rx_valid_i;
  packet_t     rx_data_i;
  logic        rx_parity_i;
  logic        frame_error_i;
  logic        overrun_error_i;
  logic        req_done_i;
  logic        tx_done_i;
  logic        line_req_o;
  logic        tx_valid_o;
  packet_t     tx_data_o;
  uart_cfg_s   cfg_o;
  logic        cfg_done_o;
  uart_error_s error_o;

  int unsigned err_cnt;
  int unsigned pass_cnt;
  int unsigned fail_cnt;
  int unsigned mark;
  int unsigned cycle_cnt;
  int unsigned edges;
  int unsigned sent;
  int unsigned k;
  uart_cfg_s   cfg;
  uart_error_s exp_err;
  uart_error_s set;
  packet_t     pkt;

  // Transmissions seen on the DUT output, one per rising edge of tx valid
  int unsigned tx_cnt = 0;
  logic        tx_prev = 1'b0;

  `include "ctrl_model.svh"

  uart_main_ctrl dut (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .cfg_i           (cfg_i),
    .std_cfg_i       (std_cfg_i),
    .cfg_req_mst_i   (cfg_req_mst_i),
    .cfg_req_slv_i   (cfg_req_slv_i),
    .irq_ack_i       (irq_ack_i),
    .rx_valid_i      (rx_valid_i),
    .rx_data_i       (rx_data_i),
    .rx_parity_i     (rx_parity_i),
    .frame_error_i   (frame_error_i),
    .overrun_error_i (overrun_error_i),
    .req_done_i      (req_done_i),
    .tx_done_i       (tx_done_i),
    .line_req_o      (line_req_o),
    .tx_valid_o      (tx_valid_o),
    .tx_data_o       (tx_data_o),
    .cfg_o           (cfg_o),
    .cfg_done_o      (cfg_done_o),
    .error_o         (error_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Watchdog that stops a hung run
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Run stopped after %0d cycles because a handshake never completed", cycle_cnt);
    $display("TEST FAILED");
    $finish;
  end

  // Transmit monitor, sampled where tx valid is stable
  always @(negedge clk_i) begin
    if (tx_valid_o && !tx_prev) begin
      tx_cnt++;
    end
    tx_prev = tx_valid_o;
  end

  task automatic check_eq(input string what, input logic [7:0] got, input logic [7:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_true(input string what, input logic ok);
    assert (ok === 1'b1) else begin
      $display("MISMATCH at %0t: %s does not hold", $time, what);
      err_cnt++;
    end
  endtask

  task automatic end_test(input string name);
    if (err_cnt == mark) begin
      $display("test %s: pass", name);
      pass_cnt++;
    end else begin
      $display("test %s: fail with %0d errors", name, err_cnt - mark);
      fail_cnt++;
    end
    mark = err_cnt;
  endtask

  task automatic wait_cfg_done();
    while (!cfg_done_o) begin
      @(negedge clk_i);
    end
  endtask

  // Full master negotiation against a peer that acknowledges everything
  task automatic run_master(input uart_cfg_s want);
    int unsigned i;
    int unsigned tx_start;
    packet_t     got;
    tx_start      = tx_cnt;
    cfg_i         = want;
    cfg_req_mst_i = 1'b1;
    @(negedge clk_i);
    cfg_req_mst_i = 1'b0;
    check_true("line request after master request", line_req_o);
    answer_line_req();
    send_rx_pkt(ACK_PKT);
    // Data width, parity mode, stop bits and end, each acknowledged by the peer
    for (i = 0; i < 4; i++) begin
      accept_tx(got);
      check_eq("master config packet", got, expected_cfg_pkt(i, want));
      send_rx_pkt(ACK_PKT);
    end
    wait_cfg_done();
    check_eq("packets sent in master negotiation", 8'(tx_cnt - tx_start), 8'd4);
  endtask

  initial begin
    void'($urandom(96601));
    err_cnt = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    mark = 0;
    rst_n_i = 1'b0;
    cfg_i = STD_CFG;
    std_cfg_i = 1'b0;
    cfg_req_mst_i = 1'b0;
    cfg_req_slv_i = 1'b0;
    irq_ack_i = 1'b0;
    rx_valid_i = 1'b0;
    rx_data_i = 8'h00;
    rx_parity_i = 1'b0;
    frame_error_i = 1'b0;
    overrun_error_i = 1'b0;
    req_done_i = 1'b0;
    tx_done_i = 1'b0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    // --------------------
    // Reset state
    check_true("tx valid low after reset", !tx_valid_o);
    check_true("line request low after reset", !line_req_o);
    check_true("cfg done low after reset", !cfg_done_o);
    check_eq("error flags after reset", 8'(error_o), 8'h00);
    check_eq("config after reset", 8'(cfg_o), 8'(STD_CFG));
    wait_cfg_done();
    end_test("reset");

    // --------------------
    // Master negotiation with random configurations
    for (k = 0; k < 5; k++) begin
      cfg = uart_cfg_s'(6'($urandom));
      run_master(cfg);
      check_eq("config after master negotiation", 8'(cfg_o), 8'(cfg));
      check_true("no config error", !error_o.configuration);
    end
    end_test("master negotiation");

    // --------------------
    // Peer that never acknowledges the line request
    cfg_i = uart_cfg_s'(6'($urandom));
    cfg_req_mst_i = 1'b1;
    @(negedge clk_i);
    cfg_req_mst_i = 1'b0;
    edges = 0;
    // Every line request is ended by the peer and then left without an acknowledgment
    while (!cfg_done_o) begin
      if (line_req_o) begin
        edges++;
        answer_line_req();
      end else begin
        @(negedge clk_i);
      end
    end
    check_eq("line requests sent", 8'(edges), 8'(MAX_RETRIES + 1));
    check_eq("config after fallback", 8'(cfg_o), 8'(STD_CFG));
    check_true("config error flag set", error_o.configuration);
    irq_ack_i = 1'b1;
    @(negedge clk_i);
    irq_ack_i = 1'b0;
    check_eq("error flags after irq ack", 8'(error_o), 8'h00);
    end_test("master timeout");

    // --------------------
    // Slave negotiation where the peer waits for each acknowledgment
    cfg = uart_cfg_s'(6'($urandom));
    cfg_req_slv_i = 1'b1;
    @(negedge clk_i);
    cfg_req_slv_i = 1'b0;
    accept_tx(pkt);
    check_eq("ack of slave request", pkt, ACK_PKT);
    for (k = 0; k < 4; k++) begin
      send_rx_pkt(expected_cfg_pkt(k, cfg));
      accept_tx(pkt);
      check_eq("ack of config packet", pkt, ACK_PKT);
    end
    wait_cfg_done();
    check_eq("config after slave negotiation", 8'(cfg_o), 8'(cfg));
    end_test("slave negotiation");

    // --------------------
    // Random received packets in IDLE with parity switched on
    cfg = uart_cfg_s'(6'($urandom));
    cfg.parity_mode = ($urandom_range(1, 0) != 0) ? PAR_ODD : PAR_EVEN;
    run_master(cfg);
    exp_err = uart_error_s'(4'b0000);
    sent = 0;
    while (sent < 200) begin
      @(negedge clk_i);
      // Flags reflect every event up to the last rising edge
      check_eq("error flags", 8'(error_o), 8'(exp_err));
      rx_valid_i      = ($urandom_range(3, 0) != 0);
      rx_data_i       = 8'($urandom);
      rx_parity_i     = 1'($urandom);
      frame_error_i   = ($urandom_range(7, 0) == 0);
      overrun_error_i = ($urandom_range(7, 0) == 0);
      irq_ack_i       = ($urandom_range(9, 0) == 0);
      set = uart_error_s'(4'b0000);
      if (rx_valid_i) begin
        sent++;
        set.parity  = expected_par_err(cfg, rx_data_i, rx_parity_i);
        set.frame   = frame_error_i;
        set.overrun = overrun_error_i;
      end
      // A new event survives an acknowledge in the same cycle
      if (irq_ack_i) exp_err = set;
      else exp_err = uart_error_s'(exp_err | set);
    end
    @(negedge clk_i);
    check_eq("error flags after last packet", 8'(error_o), 8'(exp_err));
    rx_valid_i = 1'b0;
    frame_error_i = 1'b0;
    overrun_error_i = 1'b0;
    irq_ack_i = 1'b1;
    @(negedge clk_i);
    irq_ack_i = 1'b0;
    check_eq("error flags cleared", 8'(error_o), 8'h00);
    end_test("received packets");

    // --------------------
    // Standard configuration request after a non-standard negotiation
    cfg = uart_cfg_s'(6'($urandom));
    if (cfg == STD_CFG) cfg.data_width = DW_5BIT;
    run_master(cfg);
    check_eq("config before std request", 8'(cfg_o), 8'(cfg));
    std_cfg_i = 1'b1;
    @(negedge clk_i);
    std_cfg_i = 1'b0;
    wait_cfg_done();
    check_eq("config after std request", 8'(cfg_o), 8'(STD_CFG));
    end_test("standard config");

    $display("tests passed %0d, tests failed %0d, failed checks %0d",
             pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
+incdir+dv
rtl/uart_ctrl_pkg.sv
rtl/cfg_negotiator.sv
rtl/parity_checker.sv
rtl/error_collector.sv
rtl/uart_main_ctrl.sv
dv/tb_uart_main_ctrl.sv

/* run.sh */
#!/usr/bin/env bash
# Compile and run the UART main controller testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tb_uart_main_ctrl -f files.f

output=$(./obj_dir/Vtb_uart_main_ctrl)
echo "$output"

if grep -q "TEST OK" <<< "$output"; then
  exit 0
else
  exit 1
fi
